// File: dcache.f
rtl/dcache_pkg.sv
rtl/dcache_way.sv
rtl/dcache_wbuf.sv
rtl/dcache_ctrl.sv
rtl/dcache.sv
test/dcache_mem_model.sv
test/tb_dcache.sv

// File: rtl/dcache.sv
`timescale 1ns/1ns
`default_nettype none

module dcache (
    input  logic                              clk,
    input  logic                              resetn,
    input  logic                              valid,
    input  logic                              op,
    input  logic [dcache_pkg::TAG_W-1:0]      tag,
    input  logic [dcache_pkg::INDEX_W-1:0]    index,
    input  logic [dcache_pkg::OFFSET_W-1:0]   offset,
    input  logic [dcache_pkg::STRB_W-1:0]     wstrb,
    input  logic [dcache_pkg::WORD_W-1:0]     wdata,
    output logic                              addr_ok,
    output logic                              data_ok,
    output logic [dcache_pkg::WORD_W-1:0]     rdata,
    output logic                              rd_req,
    output logic [dcache_pkg::ADDR_W-1:0]     rd_addr,
    input  logic                              rd_rdy,
    input  logic                              ret_valid,
    input  dcache_pkg::cache_line_t           ret_data,
    output logic                              wr_req,
    output logic [dcache_pkg::ADDR_W-1:0]     wr_addr,
    output dcache_pkg::cache_line_t           wr_data,
    input  logic                              wr_rdy
);

    logic                              wb_busy;
    logic                              lookup_en;
    logic [dcache_pkg::INDEX_W-1:0]    lookup_index;
    logic                              hit_store;
    logic                              hit_way;
    logic [dcache_pkg::INDEX_W-1:0]    hit_index;
    logic [dcache_pkg::OFFSET_W-1:0]   hit_offset;
    logic [dcache_pkg::STRB_W-1:0]     hit_wstrb;
    logic [dcache_pkg::WORD_W-1:0]     hit_wdata;
    logic [1:0]                        fill_en;
    logic [dcache_pkg::INDEX_W-1:0]    fill_index;
    logic [dcache_pkg::TAG_W-1:0]      fill_tag;
    dcache_pkg::cache_line_t           fill_line;
    logic                              fill_dirty;
    logic [1:0]                        st_en;
    logic [dcache_pkg::INDEX_W-1:0]    st_index;
    logic [dcache_pkg::BANK_W-1:0]     st_bank;
    logic [dcache_pkg::STRB_W-1:0]     st_wstrb;
    logic [dcache_pkg::WORD_W-1:0]     st_wdata;
    logic                              way0_v;
    logic                              way0_d;
    logic [dcache_pkg::TAG_W-1:0]      way0_tag;
    dcache_pkg::cache_line_t           way0_line;
    logic                              way1_v;
    logic                              way1_d;
    logic [dcache_pkg::TAG_W-1:0]      way1_tag;
    dcache_pkg::cache_line_t           way1_line;

    dcache_ctrl u_ctrl (.*);

    dcache_wbuf u_wbuf (.*);

    dcache_way u_way0 (
        .clk, .resetn, .lookup_en, .lookup_index,
        .st_en(st_en[0]), .st_index, .st_bank, .st_wstrb, .st_wdata,
        .fill_en(fill_en[0]), .fill_index, .fill_tag, .fill_line, .fill_dirty,
        .way_v(way0_v), .way_tag(way0_tag), .way_line(way0_line), .way_d(way0_d)
    );

    dcache_way u_way1 (
        .clk, .resetn, .lookup_en, .lookup_index,
        .st_en(st_en[1]), .st_index, .st_bank, .st_wstrb, .st_wdata,
        .fill_en(fill_en[1]), .fill_index, .fill_tag, .fill_line, .fill_dirty,
        .way_v(way1_v), .way_tag(way1_tag), .way_line(way1_line), .way_d(way1_d)
    );

endmodule

`default_nettype wire

// File: rtl/dcache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl (
    input  logic                              clk,
    input  logic                              resetn,
    input  logic                              valid,
    input  logic                              op,
    input  logic [dcache_pkg::TAG_W-1:0]      tag,
    input  logic [dcache_pkg::INDEX_W-1:0]    index,
    input  logic [dcache_pkg::OFFSET_W-1:0]   offset,
    input  logic [dcache_pkg::STRB_W-1:0]     wstrb,
    input  logic [dcache_pkg::WORD_W-1:0]     wdata,
    input  logic                              wb_busy,
    input  logic                              way0_v,
    input  logic [dcache_pkg::TAG_W-1:0]      way0_tag,
    input  dcache_pkg::cache_line_t           way0_line,
    input  logic                              way0_d,
    input  logic                              way1_v,
    input  logic [dcache_pkg::TAG_W-1:0]      way1_tag,
    input  dcache_pkg::cache_line_t           way1_line,
    input  logic                              way1_d,
    input  logic                              rd_rdy,
    input  logic                              ret_valid,
    input  dcache_pkg::cache_line_t           ret_data,
    input  logic                              wr_rdy,
    output logic                              addr_ok,
    output logic                              data_ok,
    output logic [dcache_pkg::WORD_W-1:0]     rdata,
    output logic                              lookup_en,
    output logic [dcache_pkg::INDEX_W-1:0]    lookup_index,
    output logic                              hit_store,
    output logic                              hit_way,
    output logic [dcache_pkg::INDEX_W-1:0]    hit_index,
    output logic [dcache_pkg::OFFSET_W-1:0]   hit_offset,
    output logic [dcache_pkg::STRB_W-1:0]     hit_wstrb,
    output logic [dcache_pkg::WORD_W-1:0]     hit_wdata,
    output logic [1:0]                        fill_en,
    output logic [dcache_pkg::INDEX_W-1:0]    fill_index,
    output logic [dcache_pkg::TAG_W-1:0]      fill_tag,
    output dcache_pkg::cache_line_t           fill_line,
    output logic                              fill_dirty,
    output logic                              rd_req,
    output logic [dcache_pkg::ADDR_W-1:0]     rd_addr,
    output logic                              wr_req,
    output logic [dcache_pkg::ADDR_W-1:0]     wr_addr,
    output dcache_pkg::cache_line_t           wr_data
);

    localparam logic [4:0] IDLE    = 5'b00001;
    localparam logic [4:0] LOOKUP  = 5'b00010;
    localparam logic [4:0] MISS    = 5'b00100;
    localparam logic [4:0] REPLACE = 5'b01000;
    localparam logic [4:0] REFILL  = 5'b10000;

    logic [4:0]                        state;
    logic [4:0]                        next_state;
    logic                              rb_op;
    logic [dcache_pkg::TAG_W-1:0]      rb_tag;
    logic [dcache_pkg::INDEX_W-1:0]    rb_index;
    logic [dcache_pkg::OFFSET_W-1:0]   rb_offset;
    logic [dcache_pkg::STRB_W-1:0]     rb_wstrb;
    logic [dcache_pkg::WORD_W-1:0]     rb_wdata;
    logic [dcache_pkg::BANK_W-1:0]     rb_bank;
    logic                              way0_hit;
    logic                              way1_hit;
    logic                              cache_hit;
    logic [dcache_pkg::WORD_W-1:0]     hit_word;
    logic [7:0]                        lfsr;
    logic                              lfsr_fb;
    logic                              rp_way;
    logic                              mb_v;
    logic                              mb_d;
    logic [dcache_pkg::TAG_W-1:0]      mb_tag;
    dcache_pkg::cache_line_t           mb_line;
    dcache_pkg::cache_line_t           merged;

    assign addr_ok      = (state == IDLE) && !wb_busy;
    assign lookup_en    = valid && addr_ok;
    assign lookup_index = index;

    // Request buffer
    always_ff @(posedge clk) begin
        if (lookup_en) begin
            rb_op     <= op;
            rb_tag    <= tag;
            rb_index  <= index;
            rb_offset <= offset;
            rb_wstrb  <= wstrb;
            rb_wdata  <= wdata;
        end
    end
    assign rb_bank = rb_offset[dcache_pkg::OFFSET_W-1:2];

    assign way0_hit  = way0_v && (way0_tag == rb_tag);
    assign way1_hit  = way1_v && (way1_tag == rb_tag);
    assign cache_hit = way0_hit || way1_hit;
    assign hit_word  = way1_hit ? way1_line.words[rb_bank] : way0_line.words[rb_bank];

    assign data_ok = ((state == LOOKUP) && cache_hit) || ((state == REFILL) && ret_valid);
    // Refill returns the word as memory gave it
    assign rdata   = (state == REFILL) ? ret_data.words[rb_bank] : hit_word;

    assign hit_store  = (state == LOOKUP) && cache_hit && rb_op;
    assign hit_way    = way1_hit;
    assign hit_index  = rb_index;
    assign hit_offset = rb_offset;
    assign hit_wstrb  = rb_wstrb;
    assign hit_wdata  = rb_wdata;

    // Zero state is folded into the sequence, so reset to zero is safe
    assign lfsr_fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3] ^ (lfsr[6:0] == 7'd0);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            lfsr   <= 8'd0;
            rp_way <= 1'b0;
        end else begin
            lfsr <= {lfsr[6:0], lfsr_fb};
            if (state == IDLE) begin
                rp_way <= lfsr[0];
            end
        end
    end

    // Victim snapshot
    always_ff @(posedge clk) begin
        if ((state == LOOKUP) && !cache_hit) begin
            mb_v    <= rp_way ? way1_v : way0_v;
            mb_d    <= rp_way ? way1_d : way0_d;
            mb_tag  <= rp_way ? way1_tag : way0_tag;
            mb_line <= rp_way ? way1_line : way0_line;
        end
    end

    assign wr_req  = (state == MISS) && mb_v && mb_d;
    assign wr_addr = {mb_tag, rb_index, {dcache_pkg::OFFSET_W{1'b0}}};
    assign wr_data = mb_line;

    assign rd_req  = (state == REPLACE);
    assign rd_addr = {rb_tag, rb_index, {dcache_pkg::OFFSET_W{1'b0}}};

    // Pending store bytes land on top of the refill line
    always_comb begin
        merged.bits = ret_data.bits;
        for (int b = 0; b < dcache_pkg::STRB_W; b++) begin
            if (rb_op && rb_wstrb[b]) begin
                merged.words[rb_bank][8*b +: 8] = rb_wdata[8*b +: 8];
            end
        end
    end

    assign fill_en    = {2{(state == REFILL) && ret_valid}} & {rp_way, !rp_way};
    assign fill_index = rb_index;
    assign fill_tag   = rb_tag;
    assign fill_line  = merged;
    assign fill_dirty = rb_op;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (lookup_en) next_state = LOOKUP;
            LOOKUP:  next_state = cache_hit ? IDLE : MISS;
            MISS:    if (!wr_req || wr_rdy) next_state = REPLACE;
            REPLACE: if (rd_rdy) next_state = REFILL;
            REFILL:  if (ret_valid) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!resetn)
        !(rd_req && wr_req));

    // Read address held under back-pressure
    a_rd_addr_stable: assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr));

endmodule

`default_nettype wire

// File: rtl/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // Address split
    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 8;
    localparam int OFFSET_W = 4;
    localparam int ADDR_W   = TAG_W + INDEX_W + OFFSET_W;

    // Data path
    localparam int WORD_W = 32;
    localparam int STRB_W = WORD_W / 8;
    localparam int BANKS  = 4;
    localparam int BANK_W = $clog2(BANKS);
    localparam int LINE_W = BANKS * WORD_W;

    // Array depth
    localparam int SETS = 1 << INDEX_W;

    // One line as a flat word or as its banks
    typedef union packed {
        logic [LINE_W-1:0]            bits;
        logic [BANKS-1:0][WORD_W-1:0] words;
    } cache_line_t;

endpackage

`default_nettype wire

// File: rtl/dcache_way.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_way (
    input  logic                              clk,
    input  logic                              resetn,
    input  logic                              lookup_en,
    input  logic [dcache_pkg::INDEX_W-1:0]    lookup_index,
    input  logic                              st_en,
    input  logic [dcache_pkg::INDEX_W-1:0]    st_index,
    input  logic [dcache_pkg::BANK_W-1:0]     st_bank,
    input  logic [dcache_pkg::STRB_W-1:0]     st_wstrb,
    input  logic [dcache_pkg::WORD_W-1:0]     st_wdata,
    input  logic                              fill_en,
    input  logic [dcache_pkg::INDEX_W-1:0]    fill_index,
    input  logic [dcache_pkg::TAG_W-1:0]      fill_tag,
    input  dcache_pkg::cache_line_t           fill_line,
    input  logic                              fill_dirty,
    output logic                              way_v,
    output logic [dcache_pkg::TAG_W-1:0]      way_tag,
    output dcache_pkg::cache_line_t           way_line,
    output logic                              way_d
);

    logic [dcache_pkg::TAG_W-1:0]  tag_mem  [dcache_pkg::SETS];
    logic [dcache_pkg::WORD_W-1:0] data_mem [dcache_pkg::BANKS][dcache_pkg::SETS];
    logic [dcache_pkg::SETS-1:0]   valid_bits;
    logic [dcache_pkg::SETS-1:0]   dirty_bits;
    logic [dcache_pkg::INDEX_W-1:0] rd_index;

    // Valid and dirty bits follow the same port priority as the RAMs
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (st_en) begin
            dirty_bits[st_index] <= 1'b1;
        end else if (fill_en && !lookup_en) begin
            valid_bits[fill_index] <= 1'b1;
            dirty_bits[fill_index] <= fill_dirty;
        end
    end

    // Single port: store, then lookup, then fill
    always_ff @(posedge clk) begin
        if (st_en) begin
            for (int b = 0; b < dcache_pkg::STRB_W; b++) begin
                if (st_wstrb[b]) begin
                    data_mem[st_bank][st_index][8*b +: 8] <= st_wdata[8*b +: 8];
                end
            end
        end else if (lookup_en) begin
            rd_index <= lookup_index;
            way_tag  <= tag_mem[lookup_index];
            for (int k = 0; k < dcache_pkg::BANKS; k++) begin
                way_line.words[k] <= data_mem[k][lookup_index];
            end
        end else if (fill_en) begin
            tag_mem[fill_index] <= fill_tag;
            for (int k = 0; k < dcache_pkg::BANKS; k++) begin
                data_mem[k][fill_index] <= fill_line.words[k];
            end
        end
    end

    // Flag bits line up with the registered RAM read
    assign way_v = valid_bits[rd_index];
    assign way_d = dirty_bits[rd_index];

    // Write buffer and refill never share a cycle
    a_st_fill_excl: assert property (@(posedge clk) disable iff (!resetn)
        !(st_en && fill_en));

endmodule

`default_nettype wire

// File: rtl/dcache_wbuf.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_wbuf (
    input  logic                              clk,
    input  logic                              resetn,
    input  logic                              hit_store,
    input  logic                              hit_way,
    input  logic [dcache_pkg::INDEX_W-1:0]    hit_index,
    input  logic [dcache_pkg::OFFSET_W-1:0]   hit_offset,
    input  logic [dcache_pkg::STRB_W-1:0]     hit_wstrb,
    input  logic [dcache_pkg::WORD_W-1:0]     hit_wdata,
    output logic [1:0]                        st_en,
    output logic [dcache_pkg::INDEX_W-1:0]    st_index,
    output logic [dcache_pkg::BANK_W-1:0]     st_bank,
    output logic [dcache_pkg::STRB_W-1:0]     st_wstrb,
    output logic [dcache_pkg::WORD_W-1:0]     st_wdata,
    output logic                              wb_busy
);

    localparam logic W_IDLE  = 1'b0;
    localparam logic W_WRITE = 1'b1;

    logic wstate;
    logic buf_way;

    // Back to back store hits keep the FSM in WRITE
    always_ff @(posedge clk) begin
        if (!resetn) begin
            wstate <= W_IDLE;
        end else begin
            wstate <= hit_store ? W_WRITE : W_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_store) begin
            buf_way  <= hit_way;
            st_index <= hit_index;
            st_bank  <= hit_offset[dcache_pkg::OFFSET_W-1:2];
            st_wstrb <= hit_wstrb;
            st_wdata <= hit_wdata;
        end
    end

    assign wb_busy = (wstate == W_WRITE);
    assign st_en   = {2{wb_busy}} & {buf_way, !buf_way};

    // One way per store
    a_st_onehot: assert property (@(posedge clk) disable iff (!resetn)
        |st_en |-> $onehot(st_en));

endmodule

`default_nettype wire

// File: test/dcache_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_mem_model (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            rd_req,
    input  logic [dcache_pkg::ADDR_W-1:0]   rd_addr,
    output logic                            rd_rdy,
    output logic                            ret_valid,
    output dcache_pkg::cache_line_t         ret_data,
    input  logic                            wr_req,
    input  logic [dcache_pkg::ADDR_W-1:0]   wr_addr,
    input  dcache_pkg::cache_line_t         wr_data,
    output logic                            wr_rdy
);

    localparam int LINES = 1024;

    dcache_pkg::cache_line_t lines [LINES];
    logic [31:0]             lfsr;
    logic [31:0]             lfsr_mid;
    logic [9:0]              rd_line;
    logic [1:0]              delay;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    assign lfsr_mid = lfsr_step(lfsr);

    // Word contents follow the word address
    initial begin
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
        lfsr      = 32'ha1e0;
        delay     = 2'd0;
        for (int i = 0; i < LINES; i++) begin
            for (int k = 0; k < dcache_pkg::BANKS; k++) begin
                lines[i].words[k] = (32'(i * 16 + k * 4) + 32'h1357) * 32'h9e37_79b9;
            end
        end
    end

    always @(posedge clk) begin
        if (!resetn) begin
            lfsr      <= 32'ha1e0;
            rd_rdy    <= 1'b0;
            wr_rdy    <= 1'b0;
            ret_valid <= 1'b0;
            delay     <= 2'd0;
        end else begin
            // One LFSR bit for each ready
            rd_rdy    <= lfsr[0];
            wr_rdy    <= lfsr_mid[0];
            lfsr      <= lfsr_step(lfsr_mid);
            ret_valid <= 1'b0;
            if (rd_req && rd_rdy) begin
                rd_line <= rd_addr[13:4];
                delay   <= 2'd3;
            end else if (delay != 2'd0) begin
                delay <= delay - 2'd1;
                if (delay == 2'd1) begin
                    ret_valid <= 1'b1;
                    ret_data  <= lines[rd_line];
                end
            end
            if (wr_req && wr_rdy) begin
                lines[wr_addr[13:4]] <= wr_data;
            end
        end
    end

endmodule

`default_nettype wire

// File: test/tb_dcache.sv
`timescale 1ns/1ns
`default_nettype none

module tb_dcache;

    localparam int REF_BYTES  = 1 << 14;
    localparam int MAX_CYCLES = 100 * 40 + 1000;

    logic                            clk;
    logic                            resetn;
    logic                            valid;
    logic                            op;
    logic [dcache_pkg::TAG_W-1:0]    tag;
    logic [dcache_pkg::INDEX_W-1:0]  index;
    logic [dcache_pkg::OFFSET_W-1:0] offset;
    logic [dcache_pkg::STRB_W-1:0]   wstrb;
    logic [dcache_pkg::WORD_W-1:0]   wdata;
    logic                            addr_ok;
    logic                            data_ok;
    logic [dcache_pkg::WORD_W-1:0]   rdata;
    logic                            rd_req;
    logic [dcache_pkg::ADDR_W-1:0]   rd_addr;
    logic                            rd_rdy;
    logic                            ret_valid;
    dcache_pkg::cache_line_t         ret_data;
    logic                            wr_req;
    logic [dcache_pkg::ADDR_W-1:0]   wr_addr;
    dcache_pkg::cache_line_t         wr_data;
    logic                            wr_rdy;

    logic [7:0]  ref_mem [REF_BYTES];
    logic [31:0] lfsr;
    int          cycles = 0;
    int          lat;
    logic        saw_rd;
    int          wb_count;

    dcache DUT (.*);

    dcache_mem_model mem (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $fatal(1);
        end
    end

    function automatic logic [31:0] pattern(input logic [31:0] a);
        return (a + 32'h1357) * 32'h9e37_79b9;
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] r);
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic logic [31:0] ref_word(input logic [13:0] a);
        logic [31:0] w;
        for (int b = 0; b < dcache_pkg::STRB_W; b++) begin
            w[8*b +: 8] = ref_mem[{a[13:2], 2'(b)}];
        end
        return w;
    endfunction

    function automatic logic [dcache_pkg::LINE_W-1:0] ref_line(input logic [13:0] a);
        logic [dcache_pkg::LINE_W-1:0] l;
        for (int k = 0; k < dcache_pkg::BANKS; k++) begin
            l[32*k +: 32] = ref_word({a[13:4], 2'(k), 2'b00});
        end
        return l;
    endfunction

    task automatic check(input string name, input logic [dcache_pkg::LINE_W-1:0] got,
                         input logic [dcache_pkg::LINE_W-1:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // Issue one request and wait for data_ok, watching the memory side
    task automatic access(input logic is_store, input logic [31:0] addr,
                          input logic [3:0] strb, input logic [31:0] data);
        valid  = 1'b1;
        op     = is_store;
        tag    = addr[31:12];
        index  = addr[11:4];
        offset = addr[3:0];
        wstrb  = strb;
        wdata  = data;
        saw_rd = 1'b0;
        while (!addr_ok) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        valid = 1'b0;
        lat   = 1;
        while (!data_ok) begin
            if (rd_req) begin
                saw_rd = 1'b1;
                check("rd_addr", rd_addr, {addr[31:4], 4'h0});
            end
            if (wr_req) begin
                check("wr_addr", {wr_addr[31:14], wr_addr[11:0]},
                      {18'd0, addr[11:4], 4'h0});
                check("wr_data", wr_data, ref_line(wr_addr[13:0]));
                if (wr_rdy) begin
                    wb_count++;
                end
            end
            @(posedge clk);
            #1;
            lat++;
        end
        if (is_store) begin
            for (int b = 0; b < dcache_pkg::STRB_W; b++) begin
                if (strb[b]) begin
                    ref_mem[{addr[13:2], 2'(b)}] = data[8*b +: 8];
                end
            end
        end else begin
            check("rdata", rdata, ref_word(addr[13:0]));
        end
    endtask

    task automatic first_load_miss();
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            #1;
            check("data_ok", data_ok, 0);
            check("rd_req", rd_req, 0);
            check("wr_req", wr_req, 0);
        end
        access(1'b0, 32'h0000_1124, 4'h0, 32'h0);
        check("rd_req on first load", saw_rd, 1);
    endtask

    task automatic repeated_load_hit();
        access(1'b0, 32'h0000_1124, 4'h0, 32'h0);
        check("load hit latency", lat, 1);
    endtask

    task automatic store_hit_then_load();
        access(1'b1, 32'h0000_1124, 4'b0101, 32'hdead_beef);
        check("store hit latency", lat, 1);
        @(posedge clk);
        #1;
        check("addr_ok after store hit", addr_ok, 0);
        access(1'b0, 32'h0000_1124, 4'h0, 32'h0);
        check("load after store latency", lat, 1);
    endtask

    task automatic store_miss_refill();
        access(1'b1, 32'h0000_2238, 4'b1110, 32'h1234_5678);
        check("rd_req on store miss", saw_rd, 1);
        access(1'b0, 32'h0000_2238, 4'h0, 32'h0);
        check("merged word latency", lat, 1);
        access(1'b0, 32'h0000_2230, 4'h0, 32'h0);
    endtask

    // Three tags in two ways force at least one dirty victim
    task automatic three_tag_eviction();
        int start;
        start = wb_count;
        for (int t = 1; t < 4; t++) begin
            access(1'b1, {18'd0, 2'(t), 8'h40, 4'h8}, 4'hf, 32'h1000_0000 * t + 32'h55);
        end
        check("write-back seen", wb_count > start, 1);
        for (int t = 1; t < 4; t++) begin
            access(1'b0, {18'd0, 2'(t), 8'h40, 4'h8}, 4'h0, 32'h0);
        end
    endtask

    task automatic random_mix();
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] strb;
        logic [31:0] data;
        for (int n = 0; n < 60; n++) begin
            rand_bits(6, r);
            addr = {18'd0, r[4:3], 7'b0011000, r[2], r[1:0], 2'b00};
            rand_bits(4, strb);
            rand_bits(32, data);
            access(r[5], addr, strb[3:0], data);
        end
    endtask

    initial begin
        resetn   = 1'b0;
        valid    = 1'b0;
        op       = 1'b0;
        tag      = '0;
        index    = '0;
        offset   = '0;
        wstrb    = '0;
        wdata    = '0;
        lfsr     = 32'ha1e0;
        wb_count = 0;
        for (int i = 0; i < REF_BYTES; i++) begin
            ref_mem[i] = 8'(pattern(32'(i) & ~32'd3) >> (8 * (i % 4)));
        end
        repeat (2) @(posedge clk);
        #1;
        resetn = 1'b1;
        first_load_miss();
        repeated_load_hit();
        store_hit_then_load();
        store_miss_refill();
        three_tag_eviction();
        random_mix();
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire
